// File: hdl/synth_pkg.sv
package synth_pkg;

  localparam int clock_hz = 50_000_000;
  localparam int sample_hz = 48_000;
  localparam int tick_cycles = clock_hz / sample_hz; // truncates to 1041
  localparam int tick_width = $clog2(tick_cycles);

  localparam int num_voices = 4;

  localparam int level_width = 16;
  localparam logic [level_width-1:0] level_max = '1;

  localparam int rate_width = 16;
  localparam int sustain_width = 8;
  localparam int sustain_shift = level_width - sustain_width; // sustain scales to the top byte

  localparam int key_width = 7;

  localparam int wb_addr_width = 3;
  localparam int wb_data_width = 16;

  localparam int sample_width = 16;

  localparam int status_overflow_bit = 8;

  typedef enum logic [2:0] {
    env_idle,
    env_attack,
    env_decay,
    env_sustain,
    env_release
  } env_state_t;

  typedef enum logic [wb_addr_width-1:0] {
    reg_attack   = 3'd0,
    reg_decay    = 3'd1,
    reg_sustain  = 3'd2,
    reg_release  = 3'd3,
    reg_note_on  = 3'd4,
    reg_note_off = 3'd5,
    reg_status   = 3'd6
  } reg_addr_t;

endpackage

// File: hdl/voice_controller.sv
`timescale 1ns/1ps

module voice_controller (
  input  logic                                 clock_50_000_000,
  input  logic                                 reset_l,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [synth_pkg::wb_addr_width-1:0]  wb_adr,
  input  logic [synth_pkg::wb_data_width-1:0]  wb_dat_w,
  output logic [synth_pkg::wb_data_width-1:0]  wb_dat_r,
  output logic                                 wb_ack,
  input  logic [synth_pkg::num_voices-1:0]     voice_active,
  output logic [synth_pkg::num_voices-1:0]     note_on,
  output logic [synth_pkg::num_voices-1:0]     note_off,
  output logic                                 sample_tick,
  output logic [synth_pkg::rate_width-1:0]     attack_rate,
  output logic [synth_pkg::rate_width-1:0]     decay_rate,
  output logic [synth_pkg::sustain_width-1:0]  sustain_level,
  output logic [synth_pkg::rate_width-1:0]     release_rate
);

  logic                                 bus_req;
  logic                                 bus_wr;
  logic [synth_pkg::key_width-1:0]      bus_key;
  logic [synth_pkg::tick_width-1:0]     tick_count;
  logic                                 overflow;
  logic [synth_pkg::key_width-1:0]      key_table [synth_pkg::num_voices];
  logic [synth_pkg::num_voices-1:0]     free_sel;
  logic [synth_pkg::num_voices-1:0]     match_sel;
  logic [synth_pkg::wb_data_width-1:0]  read_data;

  assign bus_req = wb_cyc && wb_stb && !wb_ack; // ack goes high on the next edge
  assign bus_wr = bus_req && wb_we;
  assign bus_key = wb_dat_w[synth_pkg::key_width-1:0];

  // lowest idle voice and lowest active voice holding the key, both one-hot
  always_comb begin
    free_sel = '0;
    match_sel = '0;
    for (int v = synth_pkg::num_voices - 1; v >= 0; v--) begin
      if (!voice_active[v]) begin
        free_sel = '0;
        free_sel[v] = 1'b1;
      end
      if (voice_active[v] && key_table[v] == bus_key) begin
        match_sel = '0;
        match_sel[v] = 1'b1;
      end
    end
  end

  always_comb begin
    read_data = '0;
    case (synth_pkg::reg_addr_t'(wb_adr))
      synth_pkg::reg_attack:  read_data = attack_rate;
      synth_pkg::reg_decay:   read_data = decay_rate;
      synth_pkg::reg_sustain: read_data[synth_pkg::sustain_width-1:0] = sustain_level;
      synth_pkg::reg_release: read_data = release_rate;
      synth_pkg::reg_status: begin
        read_data[synth_pkg::num_voices-1:0] = voice_active;
        read_data[synth_pkg::status_overflow_bit] = overflow;
      end
      default: read_data = '0; // note registers and address 7 read as zero
    endcase
  end

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      wb_ack <= 1'b0;
      note_on <= '0;
      note_off <= '0;
      overflow <= 1'b0;
      attack_rate <= '0;
      decay_rate <= '0;
      sustain_level <= '0;
      release_rate <= '0;
    end else begin
      wb_ack <= bus_req;
      note_on <= '0;
      note_off <= '0;
      if (bus_wr) begin
        case (synth_pkg::reg_addr_t'(wb_adr))
          synth_pkg::reg_attack:  attack_rate <= wb_dat_w;
          synth_pkg::reg_decay:   decay_rate <= wb_dat_w;
          synth_pkg::reg_sustain: sustain_level <= wb_dat_w[synth_pkg::sustain_width-1:0];
          synth_pkg::reg_release: release_rate <= wb_dat_w;
          synth_pkg::reg_note_on: begin
            note_on <= free_sel;
            if (free_sel == '0) begin
              overflow <= 1'b1; // every voice busy so the note is lost
            end
          end
          synth_pkg::reg_note_off: note_off <= match_sel;
          synth_pkg::reg_status:   overflow <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  // read data and the stored keys change only on a bus request
  always_ff @(posedge clock_50_000_000) begin
    if (bus_req) begin
      wb_dat_r <= read_data;
    end
    if (bus_wr && synth_pkg::reg_addr_t'(wb_adr) == synth_pkg::reg_note_on) begin
      for (int v = 0; v < synth_pkg::num_voices; v++) begin
        if (free_sel[v]) begin
          key_table[v] <= bus_key;
        end
      end
    end
  end

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      tick_count <= '0;
      sample_tick <= 1'b0;
    end else if (tick_count == synth_pkg::tick_width'(synth_pkg::tick_cycles - 1)) begin
      tick_count <= '0;
      sample_tick <= 1'b1;
    end else begin
      tick_count <= tick_count + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

// File: hdl/adsr_envelope.sv
`timescale 1ns/1ps

module adsr_envelope (
  input  logic                                 clock_50_000_000,
  input  logic                                 reset_l,
  input  logic                                 sample_tick,
  input  logic                                 note_on,
  input  logic                                 note_off,
  input  logic [synth_pkg::rate_width-1:0]     attack_rate,
  input  logic [synth_pkg::rate_width-1:0]     decay_rate,
  input  logic [synth_pkg::sustain_width-1:0]  sustain_level,
  input  logic [synth_pkg::rate_width-1:0]     release_rate,
  output logic                                 voice_active,
  output logic [synth_pkg::level_width-1:0]    level
);

  synth_pkg::env_state_t                state;
  logic [synth_pkg::level_width-1:0]    sustain_target;
  logic [synth_pkg::level_width:0]      attack_sum;
  logic [synth_pkg::level_width:0]      decay_diff;
  logic [synth_pkg::level_width:0]      release_diff;

  assign sustain_target = {sustain_level, {synth_pkg::sustain_shift{1'b0}}};
  assign voice_active = (state != synth_pkg::env_idle);

  // one extra bit catches the carry or borrow
  assign attack_sum = {1'b0, level} + {1'b0, attack_rate};
  assign decay_diff = {1'b0, level} - {1'b0, decay_rate};
  assign release_diff = {1'b0, level} - {1'b0, release_rate};

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      state <= synth_pkg::env_idle;
      level <= '0;
    end else if (note_on) begin
      state <= synth_pkg::env_attack;
      level <= '0;
    end else if (note_off) begin
      if (state != synth_pkg::env_idle) begin
        state <= synth_pkg::env_release; // release starts from wherever the level is
      end
    end else if (sample_tick) begin
      case (state)
        synth_pkg::env_attack: begin
          if (attack_sum[synth_pkg::level_width] ||
              attack_sum[synth_pkg::level_width-1:0] == synth_pkg::level_max) begin
            level <= synth_pkg::level_max;
            state <= synth_pkg::env_decay;
          end else begin
            level <= attack_sum[synth_pkg::level_width-1:0];
          end
        end
        synth_pkg::env_decay: begin
          if (decay_diff[synth_pkg::level_width] ||
              decay_diff[synth_pkg::level_width-1:0] <= sustain_target) begin
            level <= sustain_target;
            state <= synth_pkg::env_sustain;
          end else begin
            level <= decay_diff[synth_pkg::level_width-1:0];
          end
        end
        synth_pkg::env_release: begin
          if (release_diff[synth_pkg::level_width] ||
              release_diff[synth_pkg::level_width-1:0] == '0) begin
            level <= '0;
            state <= synth_pkg::env_idle;
          end else begin
            level <= release_diff[synth_pkg::level_width-1:0];
          end
        end
        default: ; // idle and sustain hold their level
      endcase
    end
  end

endmodule

// File: hdl/envelope_mixer.sv
`timescale 1ns/1ps

module envelope_mixer (
  input  logic                                                   clock_50_000_000,
  input  logic                                                   reset_l,
  input  logic                                                   sample_tick,
  input  logic [synth_pkg::num_voices*synth_pkg::level_width-1:0] levels,
  output logic [synth_pkg::sample_width-1:0]                     audio_sample,
  output logic                                                   sample_valid
);

  localparam int sum_width = synth_pkg::level_width + $clog2(synth_pkg::num_voices);

  logic                  tick_d;
  logic [sum_width-1:0]  level_sum;

  always_comb begin
    level_sum = '0;
    for (int v = 0; v < synth_pkg::num_voices; v++) begin
      level_sum = level_sum + sum_width'(levels[v*synth_pkg::level_width +: synth_pkg::level_width]);
    end
  end

  // levels settle on the edge after the tick so the sum is taken one cycle later
  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      tick_d <= 1'b0;
      sample_valid <= 1'b0;
      audio_sample <= '0;
    end else begin
      tick_d <= sample_tick;
      sample_valid <= tick_d;
      if (tick_d) begin
        audio_sample <= level_sum[sum_width-1 -: synth_pkg::sample_width]; // divide by the voice count
      end
    end
  end

endmodule

// File: hdl/envelope_synth_top.sv
`timescale 1ns/1ps

module envelope_synth_top (
  input  logic                                 clock_50_000_000,
  input  logic                                 reset_l,
  input  logic                                 wb_cyc,
  input  logic                                 wb_stb,
  input  logic                                 wb_we,
  input  logic [synth_pkg::wb_addr_width-1:0]  wb_adr,
  input  logic [synth_pkg::wb_data_width-1:0]  wb_dat_w,
  output logic [synth_pkg::wb_data_width-1:0]  wb_dat_r,
  output logic                                 wb_ack,
  output logic [synth_pkg::sample_width-1:0]   audio_sample,
  output logic                                 sample_valid
);

  logic [synth_pkg::num_voices-1:0]                        voice_active;
  logic [synth_pkg::num_voices-1:0]                        note_on;
  logic [synth_pkg::num_voices-1:0]                        note_off;
  logic                                                    sample_tick;
  logic [synth_pkg::rate_width-1:0]                        attack_rate;
  logic [synth_pkg::rate_width-1:0]                        decay_rate;
  logic [synth_pkg::sustain_width-1:0]                     sustain_level;
  logic [synth_pkg::rate_width-1:0]                        release_rate;
  logic [synth_pkg::num_voices*synth_pkg::level_width-1:0] levels;

  voice_controller controller (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack),
    .voice_active     (voice_active),
    .note_on          (note_on),
    .note_off         (note_off),
    .sample_tick      (sample_tick),
    .attack_rate      (attack_rate),
    .decay_rate       (decay_rate),
    .sustain_level    (sustain_level),
    .release_rate     (release_rate)
  );

  for (genvar v = 0; v < synth_pkg::num_voices; v++) begin : voice_gen
    adsr_envelope envelope (
      .clock_50_000_000 (clock_50_000_000),
      .reset_l          (reset_l),
      .sample_tick      (sample_tick),
      .note_on          (note_on[v]),
      .note_off         (note_off[v]),
      .attack_rate      (attack_rate),
      .decay_rate       (decay_rate),
      .sustain_level    (sustain_level),
      .release_rate     (release_rate),
      .voice_active     (voice_active[v]),
      .level            (levels[v*synth_pkg::level_width +: synth_pkg::level_width])
    );
  end

  envelope_mixer mixer (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick),
    .levels           (levels),
    .audio_sample     (audio_sample),
    .sample_valid     (sample_valid)
  );

endmodule

// File: tests/envelope_synth_props.sv
`timescale 1ns/1ps

module envelope_synth_props (
  input logic                             clock_50_000_000,
  input logic                             reset_l,
  input logic                             wb_cyc,
  input logic                             wb_stb,
  input logic                             wb_ack,
  input logic                             sample_tick,
  input logic                             sample_valid,
  input logic [synth_pkg::num_voices-1:0] note_on
);

  int assert_failures = 0;

  ack_needs_request: assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else begin
      assert_failures++;
      $error("wb_ack rose without wb_cyc and wb_stb in the cycle before");
    end

  single_cycle_pulses: assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    (wb_ack |=> !wb_ack) and (sample_valid |=> !sample_valid))
    else begin
      assert_failures++;
      $error("wb_ack or sample_valid stayed high for more than one cycle");
    end

  note_on_one_voice: assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    $onehot0(note_on))
    else begin
      assert_failures++;
      $error("note_on pulsed more than one voice");
    end

  tick_spacing: assert property (@(posedge clock_50_000_000) disable iff (!reset_l)
    sample_tick |=> !sample_tick)
    else begin
      assert_failures++;
      $error("sample_tick was high on two consecutive cycles");
    end

endmodule

bind envelope_synth_top envelope_synth_props props (.*);

// File: tests/envelope_synth_tb.sv
`timescale 1ns/1ps

module envelope_synth_tb;

  logic                                clock_50_000_000;
  logic                                reset_l;
  logic                                wb_cyc;
  logic                                wb_stb;
  logic                                wb_we;
  logic [synth_pkg::wb_addr_width-1:0] wb_adr;
  logic [synth_pkg::wb_data_width-1:0] wb_dat_w;
  logic [synth_pkg::wb_data_width-1:0] wb_dat_r;
  logic                                wb_ack;
  logic [synth_pkg::sample_width-1:0]  audio_sample;
  logic                                sample_valid;

  logic [31:0]                         tests_mem [64];
  int                                  errors = 0;
  int                                  checks = 0;
  int                                  since_valid = 0; // cycles since the last sample_valid
  bit                                  timed_out = 1'b0;
  int                                  settings [4]; // attack, decay, sustain, release
  synth_pkg::env_state_t               voice_state [synth_pkg::num_voices];
  int                                  voice_level [synth_pkg::num_voices];
  int                                  voice_key [synth_pkg::num_voices];

  envelope_synth_top uut (.*);

  initial begin
    clock_50_000_000 = 1'b0;
    forever #50 clock_50_000_000 = ~clock_50_000_000;
  end

  function automatic void report_error(string msg);
    $display("ERROR %0t ns: %s", $time, msg);
    errors++;
  endfunction

  function automatic void report_timeout(string reason);
    $display("%s", reason);
    timed_out = 1'b1;
  endfunction

  function automatic void step_voice(int v);
    int lvl;
    lvl = voice_level[v];
    case (voice_state[v])
      synth_pkg::env_attack: begin
        lvl = lvl + settings[0];
        if (lvl >= 65535) begin
          lvl = 65535;
          voice_state[v] = synth_pkg::env_decay;
        end
      end
      synth_pkg::env_decay: begin
        lvl = lvl - settings[1];
        if (lvl <= settings[2] * 256) begin // sustain sets the top byte of the level
          lvl = settings[2] * 256;
          voice_state[v] = synth_pkg::env_sustain;
        end
      end
      synth_pkg::env_release: begin
        lvl = lvl - settings[3];
        if (lvl <= 0) begin
          lvl = 0;
          voice_state[v] = synth_pkg::env_idle;
        end
      end
      default: ;
    endcase
    voice_level[v] = lvl;
  endfunction

  function automatic void apply_write(int adr, logic [15:0] data);
    bit taken;
    taken = 1'b0;
    if (adr < 4) settings[adr] = (adr == 2) ? int'(data[7:0]) : int'(data);
    for (int v = 0; v < synth_pkg::num_voices; v++) begin
      if (!taken && adr == 4 && voice_state[v] == synth_pkg::env_idle) begin
        voice_state[v] = synth_pkg::env_attack;
        voice_level[v] = 0;
        voice_key[v] = data[6:0];
        taken = 1'b1;
      end
      if (!taken && adr == 5 && voice_state[v] != synth_pkg::env_idle &&
          voice_key[v] == int'(data[6:0])) begin
        voice_state[v] = synth_pkg::env_release;
        taken = 1'b1;
      end
    end
  endfunction

  // every sample is checked against the model, not only those named in the data file
  task automatic next_cycle();
    int sum;
    @(posedge clock_50_000_000);
    #5;
    since_valid++;
    if (sample_valid) begin
      sum = 0;
      for (int v = 0; v < synth_pkg::num_voices; v++) begin
        step_voice(v);
        sum += voice_level[v];
      end
      checks++;
      assert (audio_sample == sum >> 2)
        else report_error($sformatf("audio_sample %0d, model expects %0d",
                                    audio_sample, sum >> 2));
      since_valid = 0;
    end
  endtask

  task automatic wait_for_sample();
    int wait_count;
    wait_count = 0;
    do begin
      next_cycle();
      wait_count++;
    end while (!sample_valid && wait_count < 1100);
    if (!sample_valid) report_timeout("no sample_valid arrived within 1100 cycles");
  endtask

  task automatic bus_transfer(input logic we, input logic [2:0] adr, input logic [15:0] data,
                              output logic [15:0] rdata);
    int wait_count;
    rdata = '0;
    wait_count = 0;
    while (since_valid > 1020 && wait_count < 64) begin // keep note pulses clear of a tick
      next_cycle();
      wait_count++;
    end
    if (since_valid > 1020) begin
      report_timeout("sample_valid stopped arriving before a bus request");
      return;
    end
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = data;
    wait_count = 0;
    do begin
      next_cycle();
      wait_count++;
    end while (!wb_ack && wait_count < 16);
    if (!wb_ack) report_timeout("a bus request was never acknowledged");
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  initial begin
    logic [31:0]                         entry;
    logic [synth_pkg::wb_data_width-1:0] rdata;
    reset_l = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    settings = '{default: 0};
    voice_state = '{default: synth_pkg::env_idle};
    voice_level = '{default: 0};
    voice_key = '{default: -1};
    $readmemh("tests/envelope_synth_tests.txt", tests_mem);
    repeat (8) next_cycle();
    reset_l = 1'b1;
    since_valid = 0;
    for (int i = 0;
         i < 64 && !timed_out && tests_mem[i][31:28] inside {4'h1, 4'h2, 4'h3};
         i++) begin
      entry = tests_mem[i];
      case (entry[31:28])
        4'h1: begin
          bus_transfer(1'b1, entry[26:24], entry[15:0], rdata);
          apply_write(entry[26:24], entry[15:0]);
        end
        4'h2: begin
          bus_transfer(1'b0, entry[26:24], entry[15:0], rdata);
          if (!timed_out) begin
            checks++;
            assert (rdata == entry[15:0])
              else report_error($sformatf("read of address %0d gave %h, expected %h",
                                          entry[26:24], rdata, entry[15:0]));
          end
        end
        default: begin
          for (int n = 0; n < entry[23:16] && !timed_out; n++) begin
            wait_for_sample();
          end
          if (!timed_out) begin
            checks++;
            assert (audio_sample == entry[15:0])
              else report_error($sformatf("audio_sample %h after %0d samples, expected %h",
                                          audio_sample, entry[23:16], entry[15:0]));
          end
        end
      endcase
    end
    if (checks == 0) begin
      $display("no commands were read from tests/envelope_synth_tests.txt");
      errors++;
    end
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             uut.props.assert_failures);
    if (errors == 0 && uut.props.assert_failures == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
hdl/synth_pkg.sv
hdl/voice_controller.sv
hdl/adsr_envelope.sv
hdl/envelope_mixer.sv
hdl/envelope_synth_top.sv
tests/envelope_synth_props.sv
tests/envelope_synth_tb.sv

// File: tests/envelope_synth_tests.txt
// cmd_addr_count_data in hex: cmd 1 writes data to addr, cmd 2 reads addr and expects data,
// cmd 3 waits for count samples and expects data as the audio_sample of the last one
2_0_00_0000
2_1_00_0000
2_2_00_0000
2_3_00_0000
2_6_00_0000
1_0_00_2000
1_1_00_1000
1_2_00_0080
1_3_00_1000
2_0_00_2000
2_1_00_1000
2_2_00_0080
2_3_00_1000
1_4_00_003c
3_0_12_2000
1_5_00_003c
3_0_08_0000
2_6_00_0000
1_4_00_0040
3_0_01_0800
1_4_00_0041
3_0_01_1800
1_4_00_0042
3_0_01_3000
1_5_00_0041
3_0_04_6000
2_6_00_0005
1_4_00_0043
2_6_00_0007
1_4_00_0044
1_4_00_0045
2_6_00_010f
3_0_01_7fff
1_6_00_0000
1_5_00_0070
2_6_00_000f
3_0_01_93ff
